// ==== src/rob_pkg.sv ====
// Sizes and shared types for the rename core
// Used by every RTL block and the bench through rob_pkg:: scoped names

package rob_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    localparam int ROB_SZ    = 8;   // Reorder buffer entries
    localparam int ARCH_REGS = 32;  // Architectural registers

    // Derived widths
    localparam int TAG_W = $clog2(ROB_SZ);      // 3 bits for 8 tags
    localparam int REG_W = $clog2(ARCH_REGS);   // 5
    localparam int CNT_W = $clog2(ROB_SZ + 1);  // 4 bits to hold 0..ROB_SZ

    ////////////////////
    // Types
    ////////////////////

    // ROB entry index, also the rename tag
    typedef logic [TAG_W-1:0] rob_tag_t;

    // Architectural register number
    typedef logic [REG_W-1:0] arch_reg_t;

    // Occupancy from 0 up to and including ROB_SZ
    typedef logic [CNT_W-1:0] rob_count_t;

    // Tag handed out on an unmapped lookup
    localparam rob_tag_t NULL_TAG = '0;

endpackage

// ==== src/rob.sv ====
// Reorder buffer as a circular queue with count
// Allocates at tail on accept, marks done on completion, retires one done head per cycle
`timescale 1ns/1ps

module rob (
    input  logic                clock,
    input  logic                reset,
    // Dispatch side
    input  logic                accept,        // Already gated by rob_full
    input  logic                dp_has_dest,
    input  rob_pkg::arch_reg_t  dp_dest,
    // Completion strobe
    input  logic                cp_valid,
    input  rob_pkg::rob_tag_t   cp_tag,
    // Status
    output logic                rob_full,      // Combinational from count
    output rob_pkg::rob_tag_t   tail_tag,      // Tag of next allocation
    // Retirement, registered
    output logic                rt_valid,
    output rob_pkg::rob_tag_t   rt_tag,
    output rob_pkg::arch_reg_t  rt_dest,
    output logic                rt_has_dest
);

    ////////////////////
    // Entry storage
    ////////////////////

    logic [rob_pkg::ROB_SZ-1:0] ent_valid;     // Slot in flight
    logic [rob_pkg::ROB_SZ-1:0] ent_done;      // Completed, may retire
    logic [rob_pkg::ROB_SZ-1:0] ent_has_dest;  // Writes a register
    rob_pkg::arch_reg_t         ent_dest [rob_pkg::ROB_SZ];

    rob_pkg::rob_tag_t  head;        // Oldest entry
    rob_pkg::rob_tag_t  tail;        // Next free entry
    rob_pkg::rob_count_t count;      // Entries in flight
    rob_pkg::rob_count_t count_next;

    logic retire;                    // Head leaves this edge

    ////////////////////
    // Status and retire decision
    ////////////////////

    assign rob_full = (count == rob_pkg::rob_count_t'(rob_pkg::ROB_SZ));
    assign tail_tag = tail;

    // Done bit is registered, so a completion retires one edge later at earliest
    assign retire = ent_valid[head] & ent_done[head];

    // Occupancy after this edge
    always_comb begin
        case ({accept, retire})
            2'b10:   count_next = count + rob_pkg::rob_count_t'(1);
            2'b01:   count_next = count - rob_pkg::rob_count_t'(1);
            default: count_next = count;    // Neither, or alloc and retire together
        endcase
    end

    ////////////////////
    // Pointers and control bits
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            count <= count_next;

            // Completion first; allocation below never targets an in-flight slot
            if (cp_valid) begin
                ent_done[cp_tag] <= 1'b1;
            end

            if (retire) begin
                ent_valid[head] <= 1'b0;
                head <= head + rob_pkg::rob_tag_t'(1);   // Wraps at ROB_SZ
            end

            if (accept) begin
                ent_valid[tail] <= 1'b1;
                ent_done[tail]  <= 1'b0;                 // Fresh entry not done
                tail <= tail + rob_pkg::rob_tag_t'(1);
            end
        end
    end

    // Entry payload, written at allocation only
    always_ff @(posedge clock) begin
        if (accept) begin
            ent_has_dest[tail] <= dp_has_dest;
            ent_dest[tail]     <= dp_dest;
        end
    end

    ////////////////////
    // Retirement outputs
    ////////////////////

    // One pulse per head advance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rt_valid <= 1'b0;
        end else begin
            rt_valid <= retire;
        end
    end

    // Head payload captured as it leaves
    always_ff @(posedge clock) begin
        if (retire) begin
            rt_tag      <= head;
            rt_dest     <= ent_dest[head];
            rt_has_dest <= ent_has_dest[head];
        end
    end

endmodule

// ==== src/map_table.sv ====
// Register map from architectural register to producing ROB tag
// Combinational source lookups with completion bypass; updated on accept, completion and retire
`timescale 1ns/1ps

module map_table (
    input  logic                clock,
    input  logic                reset,
    // Dispatch side
    input  logic                accept,
    input  logic                dp_has_dest,
    input  rob_pkg::arch_reg_t  dp_dest,
    input  rob_pkg::arch_reg_t  dp_src1,
    input  rob_pkg::arch_reg_t  dp_src2,
    input  rob_pkg::rob_tag_t   tail_tag,      // Tag given to this instruction
    // Completion strobe
    input  logic                cp_valid,
    input  rob_pkg::rob_tag_t   cp_tag,
    // Retirement from ROB
    input  logic                rt_valid,
    input  rob_pkg::rob_tag_t   rt_tag,
    input  rob_pkg::arch_reg_t  rt_dest,
    input  logic                rt_has_dest,
    // Lookup results, combinational
    output rob_pkg::rob_tag_t   src1_tag,
    output logic                src1_ready,
    output rob_pkg::rob_tag_t   src2_tag,
    output logic                src2_ready
);

    logic [rob_pkg::ARCH_REGS-1:0] map_valid;  // Register has an in-flight producer
    logic [rob_pkg::ARCH_REGS-1:0] map_ready;  // Producer already completed
    rob_pkg::rob_tag_t             map_tag [rob_pkg::ARCH_REGS];

    ////////////////////
    // Lookup
    ////////////////////

    // Unmapped reads as ready; mapped is ready if stored or completing now
    function automatic logic lookup_ready(input rob_pkg::arch_reg_t r);
        logic bypass;
        bypass = cp_valid && (cp_tag == map_tag[r]);
        return !map_valid[r] || map_ready[r] || bypass;
    endfunction

    // Reads old state, so a source equal to its own dest sees the previous mapping
    assign src1_tag   = map_valid[dp_src1] ? map_tag[dp_src1] : rob_pkg::NULL_TAG;
    assign src1_ready = lookup_ready(dp_src1);
    assign src2_tag   = map_valid[dp_src2] ? map_tag[dp_src2] : rob_pkg::NULL_TAG;
    assign src2_ready = lookup_ready(dp_src2);

    ////////////////////
    // Update
    ////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            map_valid <= '0;
            map_ready <= '0;
        end else begin
            // Completion marks every mapping of that tag
            for (int i = 0; i < rob_pkg::ARCH_REGS; i++) begin
                if (cp_valid && map_valid[i] && (map_tag[i] == cp_tag)) begin
                    map_ready[i] <= 1'b1;
                end
            end

            // Retire clears only if no younger producer took the register
            if (rt_valid && rt_has_dest && map_valid[rt_dest]
                    && (map_tag[rt_dest] == rt_tag)) begin
                map_valid[rt_dest] <= 1'b0;
            end

            // New mapping last, wins over a same-edge retire clear
            if (accept && dp_has_dest) begin
                map_valid[dp_dest] <= 1'b1;
                map_ready[dp_dest] <= 1'b0;
            end
        end
    end

    // Tag storage, meaningful only where map_valid is set
    always_ff @(posedge clock) begin
        if (accept && dp_has_dest) begin
            map_tag[dp_dest] <= tail_tag;
        end
    end

endmodule

// ==== src/dispatch_ctrl.sv ====
// Dispatch acceptance and the registered reservation-station packet
// Merges the ROB tail tag with the map table source lookups
`timescale 1ns/1ps

module dispatch_ctrl (
    input  logic               clock,
    input  logic               reset,
    // Instruction stream
    input  logic               dp_valid,
    // From ROB
    input  logic               rob_full,
    input  rob_pkg::rob_tag_t  tail_tag,
    // From map table
    input  rob_pkg::rob_tag_t  src1_tag,
    input  logic               src1_ready,
    input  rob_pkg::rob_tag_t  src2_tag,
    input  logic               src2_ready,
    // Acceptance, combinational
    output logic               accept,
    output logic               dp_ready,
    // Reservation-station packet, registered
    output logic               rs_valid,
    output rob_pkg::rob_tag_t  rs_tag,
    output rob_pkg::rob_tag_t  rs_src1_tag,
    output logic               rs_src1_ready,
    output rob_pkg::rob_tag_t  rs_src2_tag,
    output logic               rs_src2_ready
);

    ////////////////////
    // Acceptance
    ////////////////////

    // Full blocks dispatch even when the head retires this cycle
    assign dp_ready = ~rob_full;
    assign accept   = dp_valid & ~rob_full;   // Drives ROB alloc and map write

    ////////////////////
    // RS packet
    ////////////////////

    // Valid pulses one cycle after the accepting edge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rs_valid <= 1'b0;
        end else begin
            rs_valid <= accept;
        end
    end

    // Payload held between packets
    always_ff @(posedge clock) begin
        if (accept) begin
            rs_tag        <= tail_tag;     // Tag this instruction was given
            rs_src1_tag   <= src1_tag;
            rs_src1_ready <= src1_ready;   // Includes completion bypass
            rs_src2_tag   <= src2_tag;
            rs_src2_ready <= src2_ready;
        end
    end

endmodule

// ==== src/rename_top.sv ====
// Top of the rename core, wiring ROB, map table and dispatch control
// Instruction stream and completion in, RS packet and retirement out
`timescale 1ns/1ps

module rename_top (
    input  logic                clock,
    input  logic                reset,
    // Dispatch
    input  logic                dp_valid,
    input  logic                dp_has_dest,
    input  rob_pkg::arch_reg_t  dp_dest,
    input  rob_pkg::arch_reg_t  dp_src1,
    input  rob_pkg::arch_reg_t  dp_src2,
    output logic                dp_ready,
    // Completion
    input  logic                cp_valid,
    input  rob_pkg::rob_tag_t   cp_tag,
    // RS packet
    output logic                rs_valid,
    output rob_pkg::rob_tag_t   rs_tag,
    output rob_pkg::rob_tag_t   rs_src1_tag,
    output logic                rs_src1_ready,
    output rob_pkg::rob_tag_t   rs_src2_tag,
    output logic                rs_src2_ready,
    // Retirement
    output logic                rt_valid,
    output rob_pkg::rob_tag_t   rt_tag,
    output rob_pkg::arch_reg_t  rt_dest,
    output logic                rt_has_dest
);

    logic               accept;     // Dispatch control to ROB and map
    logic               rob_full;
    rob_pkg::rob_tag_t  tail_tag;
    rob_pkg::rob_tag_t  src1_tag;
    rob_pkg::rob_tag_t  src2_tag;
    logic               src1_ready;
    logic               src2_ready;

    rob i_rob (
        .clock, .reset,
        .accept, .dp_has_dest, .dp_dest,
        .cp_valid, .cp_tag,
        .rob_full, .tail_tag,
        .rt_valid, .rt_tag, .rt_dest, .rt_has_dest   // Also fed to the map
    );

    map_table i_map (
        .clock, .reset,
        .accept, .dp_has_dest, .dp_dest, .dp_src1, .dp_src2,
        .tail_tag, .cp_valid, .cp_tag,
        .rt_valid, .rt_tag, .rt_dest, .rt_has_dest,
        .src1_tag, .src1_ready, .src2_tag, .src2_ready
    );

    dispatch_ctrl i_dctl (
        .clock, .reset,
        .dp_valid, .rob_full, .tail_tag,
        .src1_tag, .src1_ready, .src2_tag, .src2_ready,
        .accept, .dp_ready,
        .rs_valid, .rs_tag, .rs_src1_tag, .rs_src1_ready, .rs_src2_tag, .rs_src2_ready
    );

endmodule

// ==== bench/rename_assert.sv ====
// Concurrent checks on ROB occupancy, retire pulses and full gating
// Bound into every rob instance
`timescale 1ns/1ps

module rename_assert (
    input logic                clock,
    input logic                reset,
    input rob_pkg::rob_count_t count,
    input logic                retire,     // Head valid and done
    input rob_pkg::rob_tag_t   head,
    input logic                rt_valid,
    input rob_pkg::rob_tag_t   rt_tag,
    input logic                accept,
    input logic                rob_full
);

    // Occupancy bound
    count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= rob_pkg::rob_count_t'(rob_pkg::ROB_SZ))
        else $error("ROB count above capacity");

    // Head moves just past the entry that rt_valid reports
    retire_pulse: assert property (@(posedge clock) disable iff (reset)
        retire |=> rt_valid && (head == rt_tag + rob_pkg::rob_tag_t'(1)))
        else $error("retire did not advance the head past the reported tag");

    // No entry retires twice in back-to-back cycles
    no_double_retire: assert property (@(posedge clock) disable iff (reset)
        rt_valid && $past(rt_valid) |-> rt_tag != $past(rt_tag))
        else $error("same tag retired in consecutive cycles");

    full_blocks: assert property (@(posedge clock) disable iff (reset)
        rob_full |-> !accept)
        else $error("accept while ROB full");

endmodule

bind rob rename_assert i_assert (
    .clock, .reset, .count, .retire, .head, .rt_valid, .rt_tag, .accept, .rob_full
);

// ==== bench/rename_checker.sv ====
// Reference model of ROB order and register map for the rename core
// Updates at rising edges, compares DUT outputs at falling edges where they are stable
`timescale 1ns/1ps

module rename_checker (
    input logic                clock,
    input logic                reset,
    input logic                dp_valid,
    input logic                dp_has_dest,
    input rob_pkg::arch_reg_t  dp_dest,
    input rob_pkg::arch_reg_t  dp_src1,
    input rob_pkg::arch_reg_t  dp_src2,
    input logic                dp_ready,
    input logic                cp_valid,
    input rob_pkg::rob_tag_t   cp_tag,
    input logic                rs_valid,
    input rob_pkg::rob_tag_t   rs_tag,
    input rob_pkg::rob_tag_t   rs_src1_tag,
    input logic                rs_src1_ready,
    input rob_pkg::rob_tag_t   rs_src2_tag,
    input logic                rs_src2_ready,
    input logic                rt_valid,
    input rob_pkg::rob_tag_t   rt_tag,
    input rob_pkg::arch_reg_t  rt_dest,
    input logic                rt_has_dest
);

    ////////////////////
    // Model state
    ////////////////////

    rob_pkg::rob_tag_t  q_tag [$];            // In-flight entries, oldest first
    rob_pkg::arch_reg_t q_dest [$];
    logic               q_has [$];
    logic [rob_pkg::ROB_SZ-1:0]    done;      // Completed per tag
    logic [rob_pkg::ARCH_REGS-1:0] m_valid;
    logic [rob_pkg::ARCH_REGS-1:0] m_ready;
    rob_pkg::rob_tag_t  m_tag [rob_pkg::ARCH_REGS];
    rob_pkg::rob_tag_t  next_tag;             // Counts up mod ROB_SZ

    // Predicted registered outputs after the last edge
    logic               exp_rs_valid;
    rob_pkg::rob_tag_t  exp_rs_tag;
    rob_pkg::rob_tag_t  exp_s1_tag;
    logic               exp_s1_rdy;
    rob_pkg::rob_tag_t  exp_s2_tag;
    logic               exp_s2_rdy;
    logic               exp_rt_valid;
    rob_pkg::rob_tag_t  exp_rt_tag;
    rob_pkg::arch_reg_t exp_rt_dest;
    logic               exp_rt_has;

    int errors    = 0;
    int checks    = 0;
    int accepts   = 0;
    int retires   = 0;
    int stalls    = 0;                        // dp_valid held against a full ROB
    int in_flight = 0;

    // Unmapped reads tag 0 and ready; mapped is ready when stored or completing now
    function automatic void lookup(input rob_pkg::arch_reg_t r,
                                   output rob_pkg::rob_tag_t t, output logic rdy);
        t   = m_valid[r] ? m_tag[r] : rob_pkg::rob_tag_t'(0);
        rdy = !m_valid[r] || m_ready[r] || (cp_valid && cp_tag == m_tag[r]);
    endfunction

    task automatic report_mismatch(input string what, input int got, input int want);
        errors++;
        $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, want);
    endtask

    ////////////////////
    // Model step at each rising edge
    ////////////////////

    always @(posedge clock) begin
        logic              acc;
        logic              ret;
        rob_pkg::rob_tag_t t1;
        rob_pkg::rob_tag_t t2;
        logic              r1;
        logic              r2;
        if (reset) begin
            q_tag.delete();
            q_dest.delete();
            q_has.delete();
            done         = '0;
            m_valid      = '0;
            m_ready      = '0;
            next_tag     = '0;
            exp_rs_valid = 1'b0;
            exp_rt_valid = 1'b0;
            in_flight    = 0;
        end else begin
            acc = dp_valid && (q_tag.size() < rob_pkg::ROB_SZ);
            if (dp_valid && !acc) stalls++;
            lookup(dp_src1, t1, r1);                  // Before own dest write
            lookup(dp_src2, t2, r2);
            ret = (q_tag.size() > 0) && done[q_tag[0]];  // Done as of before the edge

            if (cp_valid) begin
                done[cp_tag] = 1'b1;
                for (int i = 0; i < rob_pkg::ARCH_REGS; i++) begin
                    if (m_valid[i] && m_tag[i] == cp_tag) m_ready[i] = 1'b1;
                end
            end

            // Map clears one edge after rt_valid shows the retirement
            if (exp_rt_valid && exp_rt_has && m_valid[exp_rt_dest]
                    && m_tag[exp_rt_dest] == exp_rt_tag) begin
                m_valid[exp_rt_dest] = 1'b0;
            end

            exp_rt_valid = ret;
            if (ret) begin
                exp_rt_tag  = q_tag.pop_front();
                exp_rt_dest = q_dest.pop_front();
                exp_rt_has  = q_has.pop_front();
            end

            exp_rs_valid = acc;
            if (acc) begin
                q_tag.push_back(next_tag);
                q_dest.push_back(dp_dest);
                q_has.push_back(dp_has_dest);
                done[next_tag] = 1'b0;
                if (dp_has_dest) begin                // Newest mapping wins
                    m_valid[dp_dest] = 1'b1;
                    m_ready[dp_dest] = 1'b0;
                    m_tag[dp_dest]   = next_tag;
                end
                exp_rs_tag = next_tag;
                exp_s1_tag = t1;
                exp_s1_rdy = r1;
                exp_s2_tag = t2;
                exp_s2_rdy = r2;
                next_tag   = next_tag + rob_pkg::rob_tag_t'(1);
                accepts++;
            end
            in_flight = q_tag.size();
        end
    end

    ////////////////////
    // Compare at falling edges
    ////////////////////

    always @(negedge clock) begin
        if (!reset) begin
            checks++;
            if (dp_ready !== (q_tag.size() < rob_pkg::ROB_SZ))
                report_mismatch("dp_ready", dp_ready, q_tag.size() < rob_pkg::ROB_SZ);
            if (rs_valid !== exp_rs_valid) begin
                report_mismatch("rs_valid", rs_valid, exp_rs_valid);
            end else if (exp_rs_valid) begin
                if (rs_tag !== exp_rs_tag) report_mismatch("rs_tag", rs_tag, exp_rs_tag);
                if (rs_src1_tag !== exp_s1_tag)
                    report_mismatch("rs_src1_tag", rs_src1_tag, exp_s1_tag);
                if (rs_src1_ready !== exp_s1_rdy)
                    report_mismatch("rs_src1_ready", rs_src1_ready, exp_s1_rdy);
                if (rs_src2_tag !== exp_s2_tag)
                    report_mismatch("rs_src2_tag", rs_src2_tag, exp_s2_tag);
                if (rs_src2_ready !== exp_s2_rdy)
                    report_mismatch("rs_src2_ready", rs_src2_ready, exp_s2_rdy);
            end
            if (rt_valid !== exp_rt_valid) begin
                report_mismatch("rt_valid", rt_valid, exp_rt_valid);
            end else if (exp_rt_valid) begin
                retires++;
                if (rt_tag !== exp_rt_tag) report_mismatch("rt_tag", rt_tag, exp_rt_tag);
                if (rt_dest !== exp_rt_dest) report_mismatch("rt_dest", rt_dest, exp_rt_dest);
                if (rt_has_dest !== exp_rt_has)
                    report_mismatch("rt_has_dest", rt_has_dest, exp_rt_has);
            end
        end
    end

endmodule

// ==== bench/rename_tb.sv ====
// Testbench for the rename core with seeded random dispatch and completion in five phases
// Top module of the simulation with the DUT, the reference checker and the run limit
`timescale 1ns/1ps

module rename_tb;

    localparam int RESET_CYCLES = 10;
    localparam int PHASES       = 5;
    localparam int PHASE_CYCLES = 400;
    localparam int TIMEOUT      = RESET_CYCLES + PHASES * PHASE_CYCLES + 490;  // 2500

    logic               clock = 1'b0;
    logic               reset = 1'b1;
    logic               dp_valid = 1'b0;
    logic               dp_has_dest = 1'b0;
    rob_pkg::arch_reg_t dp_dest = '0;
    rob_pkg::arch_reg_t dp_src1 = '0;
    rob_pkg::arch_reg_t dp_src2 = '0;
    logic               cp_valid = 1'b0;
    rob_pkg::rob_tag_t  cp_tag = '0;
    logic               dp_ready;
    logic               rs_valid;
    rob_pkg::rob_tag_t  rs_tag;
    rob_pkg::rob_tag_t  rs_src1_tag;
    logic               rs_src1_ready;
    rob_pkg::rob_tag_t  rs_src2_tag;
    logic               rs_src2_ready;
    logic               rt_valid;
    rob_pkg::rob_tag_t  rt_tag;
    rob_pkg::arch_reg_t rt_dest;
    logic               rt_has_dest;

    int                seed = 85678;
    int                cycles = 0;
    logic              accepted = 1'b0;   // Instruction on the bus is taken at next edge
    rob_pkg::rob_tag_t alloc_tag = '0;    // Tag the bench expects to be handed out
    rob_pkg::rob_tag_t pending [$];       // In flight and not yet completed

    always #5 clock = ~clock;

    rename_top i_dut (.*);
    rename_checker i_chk (.*);

    // Run limit
    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Drive one falling edge with a completion and a new or held instruction
    task automatic drive_cycle(input int valid_pct, input int comp_pct,
                               input int reg_span, input int dest_pct);
        int idx;
        @(negedge clock);
        if (accepted) begin
            pending.push_back(alloc_tag);
            alloc_tag = alloc_tag + rob_pkg::rob_tag_t'(1);
        end
        cp_valid = 1'b0;
        if (pending.size() > 0 && rand_below(100) < comp_pct) begin
            idx      = rand_below(pending.size());   // Any order, not only oldest
            cp_valid = 1'b1;
            cp_tag   = pending[idx];
            pending.delete(idx);
        end
        if (accepted || !dp_valid) begin             // Stalled instruction stays put
            dp_valid    = rand_below(100) < valid_pct;
            dp_has_dest = rand_below(100) < dest_pct;
            dp_dest     = rob_pkg::arch_reg_t'(rand_below(reg_span));
            dp_src1     = rob_pkg::arch_reg_t'(rand_below(reg_span));
            dp_src2     = rob_pkg::arch_reg_t'(rand_below(reg_span));
        end
        accepted = dp_valid && dp_ready;             // dp_ready depends on count only
    endtask

    task automatic run_phase(input int num, input string name, input int valid_pct,
                             input int comp_pct, input int reg_span, input int dest_pct,
                             input int hold_off);
        int err0;
        int acc0;
        int ret0;
        int stl0;
        err0 = i_chk.errors;
        acc0 = i_chk.accepts;
        ret0 = i_chk.retires;
        stl0 = i_chk.stalls;
        for (int c = 0; c < PHASE_CYCLES; c++) begin
            drive_cycle(valid_pct, (c < hold_off) ? 0 : comp_pct, reg_span, dest_pct);
        end
        $display("phase %0d %s: %0d errors, %0d accepts, %0d retires, %0d stall cycles",
                 num, name, i_chk.errors - err0, i_chk.accepts - acc0,
                 i_chk.retires - ret0, i_chk.stalls - stl0);
    endtask

    initial begin
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;

        run_phase(1, "tag_alloc",    70, 50, 32, 60, 0);
        run_phase(2, "source_deps",  80, 40, 4,  80, 0);    // Few registers, many hits
        run_phase(3, "full_stall",   100, 40, 32, 60, 150); // No completions at first
        run_phase(4, "retire_order", 60, 70, 8,  60, 0);
        run_phase(5, "retire_clear", 50, 80, 2,  70, 0);    // Two registers, heavy remap

        // Drain until the model ROB is empty
        while (pending.size() > 0 || i_chk.in_flight > 0 || accepted) begin
            drive_cycle(0, 100, 32, 0);
        end
        repeat (3) @(negedge clock);

        $display("checks %0d, errors %0d, accepts %0d, retires %0d",
                 i_chk.checks, i_chk.errors, i_chk.accepts, i_chk.retires);
        if (i_chk.errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
src/rob_pkg.sv
src/rob.sv
src/map_table.sv
src/dispatch_ctrl.sv
src/rename_top.sv
bench/rename_assert.sv
bench/rename_checker.sv
bench/rename_tb.sv

// ==== Makefile ====
TOP = rename_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
